/* bench/box_plotter_assert.sv */
`timescale 1ns/100ps

module box_plotter_assert #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input logic                       clk,
	input logic                       resetn,
	input plot_ctrl_pkg::plot_state_t state,
	input plot_pkg::pixel_t           pixel,
	input logic                       pixel_we
);

	// frame buffer must only ever see on-screen writes
	property write_on_screen;
		@(posedge clk) disable iff (!resetn)
		pixel_we |-> (32'(pixel.x) < SCREEN_W) && (32'(pixel.y) < SCREEN_H);
	endproperty

	property quiet_in_reset;
		@(posedge clk) !resetn |=> !pixel_we;
	endproperty

	// done lasts one cycle
	property done_to_load_x;
		@(posedge clk) disable iff (!resetn)
		state == plot_ctrl_pkg::done |=> state == plot_ctrl_pkg::load_x;
	endproperty

	assert property (write_on_screen) else $error("pixel_we high with an off-screen pixel");
	assert property (quiet_in_reset) else $error("pixel_we high while in reset");
	assert property (done_to_load_x) else $error("controller did not return to load_x after done");

endmodule

bind plot_control box_plotter_assert u_fsm_assert (
	.clk      (clk),
	.resetn   (resetn),
	.state    (state),
	.pixel    ('0),     // no pixel port here
	.pixel_we (1'b0)
);

bind pixel_output box_plotter_assert #(
	.SCREEN_W (SCREEN_W),
	.SCREEN_H (SCREEN_H)
) u_port_assert (
	.clk      (clk),
	.resetn   (resetn),
	.state    (plot_ctrl_pkg::load_x),
	.pixel    (pixel),
	.pixel_we (pixel_we)
);

/* bench/box_plotter_tb.sv */
`timescale 1ns/100ps

module box_plotter_tb;

	localparam int BOX_SIZE   = 16;
	localparam int SCREEN_W   = 160;
	localparam int SCREEN_H   = 120;
	localparam int CLK_PERIOD = 8;

	localparam int BOX_TESTS  = 5;
	localparam int EDGE_TESTS = 4;
	localparam int MID_TESTS  = 2;
	localparam int COMMANDS   = BOX_TESTS + EDGE_TESTS + MID_TESTS + 2; // idle sweep, last box
	localparam int SWEEP_LEN  = SCREEN_W * SCREEN_H;
	localparam int WATCHDOG_CYCLES = COMMANDS * SWEEP_LEN * 2 + 2000;

	logic             clk;
	logic             resetn;
	logic             go;
	logic             plot;
	logic             background;
	logic [7:0]       coord_in;
	plot_pkg::color_t color_in;
	plot_pkg::pixel_t pixel;
	logic             pixel_we;
	logic             busy;

	plot_pkg::pixel_t exp_q[$];  // writes still to come, in order
	logic [31:0]      lcg_state = 32'hd8fa_c58d;

	box_plotter #(
		.BOX_SIZE (BOX_SIZE),
		.SCREEN_W (SCREEN_W),
		.SCREEN_H (SCREEN_H)
	) uut (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.plot       (plot),
		.background (background),
		.coord_in   (coord_in),
		.color_in   (color_in),
		.pixel      (pixel),
		.pixel_we   (pixel_we),
		.busy       (busy)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(int lo, int hi);
		logic [31:0] r;
		r = next_random();
		return lo + int'({8'd0, r[31:8]} % 32'(hi - lo + 1)); // low bits are weak
	endfunction

	function automatic plot_pkg::pixel_t make_pixel(int x, int y, plot_pkg::color_t c);
		plot_pkg::pixel_t p;
		p.x     = plot_pkg::coord_x_t'(x);
		p.y     = plot_pkg::coord_y_t'(y);
		p.color = c;
		return p;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("Error at %0d ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual));
	endtask

	// first issued offsets of a box, raster order, clipped to the screen
	task automatic expect_box(int cx, int cy, plot_pkg::color_t c, int issued);
		int x;
		int y;
		for (int i = 0; i < issued; i++) begin
			x = cx + i % BOX_SIZE;
			y = cy + i / BOX_SIZE;
			if (x < SCREEN_W && y < SCREEN_H)
				exp_q.push_back(make_pixel(x, y, c));
		end
	endtask

	task automatic expect_sweep();
		for (int y = 0; y < SCREEN_H; y++)
			for (int x = 0; x < SCREEN_W; x++)
				exp_q.push_back(make_pixel(x, y, plot_pkg::color_t'(0)));
	endtask

	// go pulse with x, then plot pulse with y and colour; returns on the edge plot drops
	task automatic enter_command(int cx, int cy, plot_pkg::color_t c);
		int go_len;
		int plot_len;
		go_len   = rand_range(1, 4);
		plot_len = rand_range(1, 4);
		@(posedge clk);
		coord_in <= 8'(cx);
		go       <= 1'b1;
		repeat (go_len) @(posedge clk);
		go       <= 1'b0;
		coord_in <= 8'(cy);
		color_in <= c;
		@(posedge clk);
		check_value("busy", 32'd0, 32'(busy)); // command not complete yet
		plot <= 1'b1;
		repeat (plot_len) @(posedge clk);
		plot <= 1'b0;
	endtask

	task automatic pulse_background();
		background <= 1'b1;
		@(posedge clk);
		background <= 1'b0;
	endtask

	task automatic wait_idle();
		do
			@(posedge clk);
		while (busy !== 1'b0);
	endtask

	task automatic run_box(int cx, int cy, plot_pkg::color_t c);
		expect_box(cx, cy, c, BOX_SIZE * BOX_SIZE);
		enter_command(cx, cy, c);
		wait_idle();
		check_value("pending writes", 32'd0, 32'(exp_q.size()));
	endtask

	// every strobe must match the head of the expected list
	always @(posedge clk) begin
		if (pixel_we === 1'b1) begin
			if (exp_q.size() == 0)
				abort_run($sformatf("pixel_we high at %0d ns with no write expected", $time));
			else begin
				check_value("pixel", 32'(exp_q[0]), 32'(pixel));
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout: the plotter hung and never went idle");
	end

	initial begin
		int cx;
		int cy;
		int delay;
		plot_pkg::color_t c;

		resetn     = 1'b0;
		go         = 1'b0;
		plot       = 1'b0;
		background = 1'b0;
		coord_in   = '0;
		color_in   = '0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		repeat (8) begin
			@(posedge clk);
			check_value("busy", 32'd0, 32'(busy));
		end

		for (int i = 0; i < BOX_TESTS; i++) begin
			cx = rand_range(0, SCREEN_W - BOX_SIZE);
			cy = rand_range(0, SCREEN_H - BOX_SIZE);
			c  = plot_pkg::color_t'(rand_range(0, 7));
			run_box(cx, cy, c);
		end

		// boxes over the right or the bottom edge
		for (int i = 0; i < EDGE_TESTS; i++) begin
			if (i % 2 == 0) begin
				cx = rand_range(SCREEN_W - BOX_SIZE + 1, SCREEN_W - 1);
				cy = rand_range(0, SCREEN_H - 1);
			end else begin
				cx = rand_range(0, SCREEN_W - 1);
				cy = rand_range(SCREEN_H - BOX_SIZE + 1, SCREEN_H - 1);
			end
			c = plot_pkg::color_t'(rand_range(0, 7));
			run_box(cx, cy, c);
		end

		expect_sweep();
		pulse_background();
		wait_idle();
		check_value("pending writes", 32'd0, 32'(exp_q.size()));

		// request lands delay cycles after plot drops, draws come every 2nd cycle
		for (int i = 0; i < MID_TESTS; i++) begin
			cx    = rand_range(0, SCREEN_W - BOX_SIZE);
			cy    = rand_range(0, SCREEN_H - BOX_SIZE);
			c     = plot_pkg::color_t'(rand_range(1, 7));
			delay = rand_range(1, 2 * BOX_SIZE * BOX_SIZE - 2);
			expect_box(cx, cy, c, (delay - 1) / 2 + 1);
			expect_sweep();
			enter_command(cx, cy, c);
			repeat (delay) @(posedge clk);
			pulse_background();
			wait_idle();
			check_value("pending writes", 32'd0, 32'(exp_q.size()));
		end

		cx = rand_range(0, SCREEN_W - BOX_SIZE);
		cy = rand_range(0, SCREEN_H - BOX_SIZE);
		c  = plot_pkg::color_t'(rand_range(0, 7));
		run_box(cx, cy, c);

		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("run ended with expected writes still pending");
		end
	end

endmodule

/* box_plotter.f */
hw/plot_pkg.sv
hw/plot_ctrl_pkg.sv
hw/plot_control.sv
hw/plot_datapath.sv
hw/pixel_output.sv
hw/box_plotter.sv
bench/box_plotter_assert.sv
bench/box_plotter_tb.sv

/* hw/box_plotter.sv */
`timescale 1ns/100ps

module box_plotter #(
	parameter int BOX_SIZE = 16,
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic             go,
	input  logic             plot,
	input  logic             background,
	input  logic [7:0]       coord_in,
	input  plot_pkg::color_t color_in,
	output plot_pkg::pixel_t pixel,
	output logic             pixel_we,
	output logic             busy
);

	plot_ctrl_pkg::ctrl_t ctrl;
	logic                 box_last;
	logic                 sweep_last;
	plot_pkg::pixel_t     cand;
	logic                 cand_we;

	plot_control u_control (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.plot       (plot),
		.background (background),
		.box_last   (box_last),
		.sweep_last (sweep_last),
		.ctrl       (ctrl),
		.busy       (busy)
	);

	plot_datapath #(
		.BOX_SIZE (BOX_SIZE),
		.SCREEN_W (SCREEN_W),
		.SCREEN_H (SCREEN_H)
	) u_datapath (
		.clk        (clk),
		.resetn     (resetn),
		.ctrl       (ctrl),
		.coord_in   (coord_in),
		.color_in   (color_in),
		.box_last   (box_last),
		.sweep_last (sweep_last),
		.cand       (cand),
		.cand_we    (cand_we)
	);

	pixel_output #(
		.SCREEN_W (SCREEN_W),
		.SCREEN_H (SCREEN_H)
	) u_output (
		.clk      (clk),
		.resetn   (resetn),
		.cand     (cand),
		.cand_we  (cand_we),
		.pixel    (pixel),
		.pixel_we (pixel_we)
	);

endmodule

/* hw/pixel_output.sv */
`timescale 1ns/100ps

module pixel_output #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic             clk,
	input  logic             resetn,
	input  plot_pkg::pixel_t cand,
	input  logic             cand_we,
	output plot_pkg::pixel_t pixel,
	output logic             pixel_we
);

	logic on_screen;

	// the only screen bound check in the design
	assign on_screen = (32'(cand.x) < SCREEN_W) && (32'(cand.y) < SCREEN_H);

	// hold the last written pixel between strobes
	always_ff @(posedge clk) begin
		if (cand_we)
			pixel <= cand;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			pixel_we <= 1'b0;
		else
			pixel_we <= cand_we && on_screen; // off-screen pixels dropped
	end

endmodule

/* hw/plot_control.sv */
`timescale 1ns/100ps

module plot_control (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 go,
	input  logic                 plot,
	input  logic                 background,
	input  logic                 box_last,
	input  logic                 sweep_last,
	output plot_ctrl_pkg::ctrl_t ctrl,
	output logic                 busy
);

	plot_ctrl_pkg::plot_state_t state;
	plot_ctrl_pkg::plot_state_t next_state;

	// next state
	always_comb begin
		next_state = state;
		unique case (state)
			plot_ctrl_pkg::load_x: begin
				if (go)
					next_state = plot_ctrl_pkg::load_x_wait;
			end
			plot_ctrl_pkg::load_x_wait: begin
				if (!go)
					next_state = plot_ctrl_pkg::load_y_color; // go has fallen
			end
			plot_ctrl_pkg::load_y_color: begin
				if (plot)
					next_state = plot_ctrl_pkg::wait_plot;
			end
			plot_ctrl_pkg::wait_plot: begin
				if (!plot)
					next_state = plot_ctrl_pkg::draw;
			end
			plot_ctrl_pkg::draw: begin
				// box_last reflects the offset written in this cycle
				if (box_last)
					next_state = plot_ctrl_pkg::done;
				else
					next_state = plot_ctrl_pkg::draw_step;
			end
			plot_ctrl_pkg::draw_step: begin
				next_state = plot_ctrl_pkg::draw;
			end
			plot_ctrl_pkg::done: begin
				next_state = plot_ctrl_pkg::load_x;
			end
			plot_ctrl_pkg::background: begin
				if (sweep_last)
					next_state = plot_ctrl_pkg::done;
			end
			default: begin
				next_state = plot_ctrl_pkg::load_x;
			end
		endcase

		// background request wins everywhere but in the sweep itself
		if (background && state != plot_ctrl_pkg::background)
			next_state = plot_ctrl_pkg::background;
	end

	// one control word per state
	always_comb begin
		ctrl = '0;
		unique case (state)
			plot_ctrl_pkg::load_x: begin
				ctrl.load_x = 1'b1;
			end
			plot_ctrl_pkg::load_y_color: begin
				ctrl.load_yc = 1'b1;
			end
			plot_ctrl_pkg::draw: begin
				ctrl.box_write = 1'b1;
			end
			plot_ctrl_pkg::draw_step: begin
				ctrl.box_step = 1'b1;
			end
			plot_ctrl_pkg::done: begin
				ctrl.count_clear = 1'b1;
			end
			plot_ctrl_pkg::background: begin
				ctrl.sweep       = 1'b1;
				ctrl.sweep_write = 1'b1;
			end
			default: begin
				ctrl = '0; // load_x_wait and wait_plot only wait
			end
		endcase
	end

	// idle while the operator is still entering a command
	always_comb begin
		unique case (state)
			plot_ctrl_pkg::load_x,
			plot_ctrl_pkg::load_x_wait,
			plot_ctrl_pkg::load_y_color: busy = 1'b0;
			default:                     busy = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= plot_ctrl_pkg::load_x;
		else
			state <= next_state;
	end

endmodule

/* hw/plot_ctrl_pkg.sv */
package plot_ctrl_pkg;

	// controller states, held in three bits
	typedef enum logic [2:0] {
		load_x       = 3'd0,
		load_x_wait  = 3'd1,
		load_y_color = 3'd2,
		wait_plot    = 3'd3,
		draw         = 3'd4,
		draw_step    = 3'd5,
		done         = 3'd6,
		background   = 3'd7
	} plot_state_t;

	// control word from the FSM to the datapath
	typedef struct packed {
		logic load_x;      // capture x from coord_in
		logic load_yc;     // capture y and colour
		logic box_write;   // issue corner plus offset
		logic box_step;    // advance box offset, x fastest
		logic sweep;       // candidate comes from the sweep counter
		logic count_clear; // zero both counters
		logic sweep_write; // issue sweep pixel and advance
	} ctrl_t;

endpackage

/* hw/plot_datapath.sv */
`timescale 1ns/100ps

module plot_datapath #(
	parameter int BOX_SIZE = 16,
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  plot_ctrl_pkg::ctrl_t ctrl,
	input  logic [7:0]           coord_in,
	input  plot_pkg::color_t     color_in,
	output logic                 box_last,
	output logic                 sweep_last,
	output plot_pkg::pixel_t     cand,
	output logic                 cand_we
);

	localparam int OFF_W = (BOX_SIZE > 1) ? $clog2(BOX_SIZE) : 1;

	typedef logic [OFF_W-1:0] offset_t;
	typedef logic [8:0]       sum_t;    // corner plus offset with carry

	localparam offset_t            OFF_LAST     = offset_t'(BOX_SIZE - 1);
	localparam plot_pkg::coord_x_t SWEEP_X_LAST = plot_pkg::coord_x_t'(SCREEN_W - 1);
	localparam plot_pkg::coord_y_t SWEEP_Y_LAST = plot_pkg::coord_y_t'(SCREEN_H - 1);

	plot_pkg::coord_x_t corner_x;
	plot_pkg::coord_y_t corner_y;
	plot_pkg::color_t   color;

	offset_t off_x;
	offset_t off_y;

	plot_pkg::coord_x_t sweep_x;
	plot_pkg::coord_y_t sweep_y;

	sum_t sum_x;
	sum_t sum_y;

	// box corner and colour
	always_ff @(posedge clk) begin
		if (ctrl.load_x)
			corner_x <= plot_pkg::coord_x_t'(coord_in);
		if (ctrl.load_yc) begin
			corner_y <= coord_in[6:0]; // y uses the low bits only
			color    <= color_in;
		end
	end

	// box offset, raster order with x fastest
	assign box_last = (off_x == OFF_LAST) && (off_y == OFF_LAST);

	always_ff @(posedge clk) begin
		if (!resetn || ctrl.count_clear) begin
			off_x <= '0;
			off_y <= '0;
		end else if (ctrl.box_step) begin
			if (off_x == OFF_LAST) begin
				off_x <= '0;
				off_y <= off_y + offset_t'(1);
			end else begin
				off_x <= off_x + offset_t'(1);
			end
		end
	end

	// whole screen sweep, one pixel per cycle
	assign sweep_last = (sweep_x == SWEEP_X_LAST) && (sweep_y == SWEEP_Y_LAST);

	always_ff @(posedge clk) begin
		if (!resetn || ctrl.count_clear) begin
			sweep_x <= '0;
			sweep_y <= '0;
		end else if (ctrl.sweep_write) begin
			if (sweep_x == SWEEP_X_LAST) begin
				sweep_x <= '0;
				sweep_y <= sweep_last ? '0 : sweep_y + plot_pkg::coord_y_t'(1);
			end else begin
				sweep_x <= sweep_x + plot_pkg::coord_x_t'(1);
			end
		end
	end

	assign sum_x = sum_t'(corner_x) + sum_t'(off_x);
	assign sum_y = sum_t'(corner_y) + sum_t'(off_y);

	// a carry out of a field pins it at its top value,
	// which lies past the screen edge and gets clipped downstream
	always_comb begin
		if (ctrl.sweep) begin
			cand.x     = sweep_x;
			cand.y     = sweep_y;
			cand.color = plot_pkg::COLOR_BLANK;
		end else begin
			cand.x     = sum_x[8] ? plot_pkg::X_FIELD_MAX : sum_x[7:0];
			cand.y     = (sum_y[8:7] != 2'b00) ? plot_pkg::Y_FIELD_MAX : sum_y[6:0];
			cand.color = color;
		end
	end

	assign cand_we = ctrl.box_write | ctrl.sweep_write;

endmodule

/* hw/plot_pkg.sv */
package plot_pkg;

	// screen coordinates, wide enough for the 160 by 120 frame buffer
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// 3-bit rgb, one bit per channel
	typedef logic [2:0] color_t;

	// one pixel write as seen by the frame buffer port
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pixel_t;

	// colour used by the full screen sweep
	localparam color_t COLOR_BLANK = 3'd0;

	// largest values the coordinate fields can hold
	localparam coord_x_t X_FIELD_MAX = '1;
	localparam coord_y_t Y_FIELD_MAX = '1;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the box plotter testbench with Verilator
set -e

verilator --binary --assert -j 0 --top-module box_plotter_tb -f box_plotter.f \
	--Mdir obj_dir -o box_plotter_sim
./obj_dir/box_plotter_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
echo "simulation passed"
